//--- all.f
hw/engine_pkg.sv
hw/engine_ctrl.sv
hw/engine_addr_gen.sv
hw/engine_mac.sv
hw/engine_pool.sv
hw/engine_wb.sv
hw/engine_top.sv
tests/dma_mem_model.sv
tests/engine_tb.sv

//--- hw/engine_addr_gen.sv
`timescale 1ns/1ns
`default_nettype none

module engine_addr_gen (
	input  logic               clk,
	input  logic               i_rst_n,
	input  logic               i_start,
	input  logic               i_fetch,
	input  logic               i_write_done,
	input  engine_pkg::cnt_t   i_op_num,
	input  engine_pkg::addr_t  i_data_start_addr,
	input  engine_pkg::addr_t  i_weight_start_addr,
	input  engine_pkg::addr_t  i_result_start_addr,
	output engine_pkg::addr_t  o_p2_addr,
	output engine_pkg::addr_t  o_p3_addr,
	output engine_pkg::addr_t  o_p0_addr
);

	// Position inside the kernel
	engine_pkg::cnt_t wcnt;

	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_p2_addr <= '0;
			o_p3_addr <= '0;
			o_p0_addr <= '0;
			wcnt <= '0;
		end else if (i_start) begin
			o_p2_addr <= i_data_start_addr;
			o_p3_addr <= i_weight_start_addr;
			o_p0_addr <= i_result_start_addr;
			wcnt <= '0;
		end else begin
			if (i_fetch) begin
				// Data runs straight through memory
				o_p2_addr <= o_p2_addr + engine_pkg::addr_t'(1);
				// Kernel restarts for every output
				if (wcnt == i_op_num - engine_pkg::cnt_t'(1)) begin
					o_p3_addr <= i_weight_start_addr;
					wcnt <= '0;
				end else begin
					o_p3_addr <= o_p3_addr + engine_pkg::addr_t'(1);
					wcnt <= wcnt + engine_pkg::cnt_t'(1);
				end
			end
			if (i_write_done)
				o_p0_addr <= o_p0_addr + engine_pkg::addr_t'(1);
		end
	end

endmodule

`default_nettype wire

//--- hw/engine_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module engine_ctrl (
	input  logic                clk,
	input  logic                i_rst_n,
	input  logic                i_engine_valid,
	input  engine_pkg::op_t     i_op_type,
	input  engine_pkg::cnt_t    i_op_num,
	input  engine_pkg::cnt_t    i_out_count,
	input  logic                i_dma_p2_ob_we,
	input  engine_pkg::data_t   i_dma_p2_ob_data,
	input  logic                i_dma_p3_ob_we,
	input  engine_pkg::data_t   i_dma_p3_ob_data,
	input  logic                i_wb_busy,
	output logic                o_engine_ready,
	output logic                o_dma_p2_reads_en,
	output logic                o_dma_p3_reads_en,
	output logic                o_fetch,
	output logic                o_start,
	output logic                o_elem_en,
	output logic                o_elem_first,
	output logic                o_elem_last,
	output engine_pkg::data_t   o_elem_data,
	output engine_pkg::data_t   o_elem_weight,
	output logic                o_mac_sel
);

	engine_pkg::ctrl_state_t state;
	engine_pkg::ctrl_state_t state_nxt;
	engine_pkg::cnt_t        elem_cnt;
	engine_pkg::cnt_t        out_cnt;
	logic                    is_conv;
	logic                    is_pool;
	logic                    p2_pend;
	logic                    p3_pend;
	logic                    out_last;
	logic                    write_taken;

	assign is_conv = (i_op_type == engine_pkg::OP_CONV);
	assign is_pool = (i_op_type == engine_pkg::OP_MAXPOOL) ||
		(i_op_type == engine_pkg::OP_AVEPOOL);
	assign o_mac_sel = is_conv;

	assign o_start = (state == engine_pkg::S_IDLE) && i_engine_valid;
	assign o_fetch = (state == engine_pkg::S_FETCH) && (is_conv || is_pool);
	assign o_dma_p2_reads_en = o_fetch;
	// Pools never touch the weight port
	assign o_dma_p3_reads_en = o_fetch && is_conv;

	assign o_elem_en = (state == engine_pkg::S_WAIT) && !p2_pend && !p3_pend;
	assign o_elem_first = (elem_cnt == '0);
	assign o_elem_last = (elem_cnt == i_op_num - engine_pkg::cnt_t'(1));
	assign out_last = (out_cnt == i_out_count - engine_pkg::cnt_t'(1));
	assign write_taken = (state == engine_pkg::S_WRITE) && !i_wb_busy;

	always_comb begin
		state_nxt = state;
		case (state)
			engine_pkg::S_IDLE: begin
				if (i_engine_valid)
					state_nxt = engine_pkg::S_FETCH;
			end
			engine_pkg::S_FETCH: begin
				if (is_conv || is_pool)
					state_nxt = engine_pkg::S_WAIT;
				else
					state_nxt = engine_pkg::S_DONE;
			end
			engine_pkg::S_WAIT: begin
				if (o_elem_en)
					state_nxt = o_elem_last ? engine_pkg::S_REDUCE : engine_pkg::S_FETCH;
			end
			engine_pkg::S_REDUCE: state_nxt = engine_pkg::S_WRITE;
			engine_pkg::S_WRITE: begin
				if (write_taken)
					state_nxt = out_last ? engine_pkg::S_DONE : engine_pkg::S_FETCH;
			end
			engine_pkg::S_DONE: state_nxt = engine_pkg::S_RELEASE;
			engine_pkg::S_RELEASE: begin
				// Host must drop valid before the next op
				if (!i_engine_valid)
					state_nxt = engine_pkg::S_IDLE;
			end
			default: state_nxt = engine_pkg::S_IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state <= engine_pkg::S_IDLE;
			o_engine_ready <= 1'b0;
		end else begin
			state <= state_nxt;
			o_engine_ready <= (state_nxt == engine_pkg::S_DONE);
		end
	end

	// One outstanding read per port
	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			p2_pend <= 1'b0;
			p3_pend <= 1'b0;
		end else begin
			if (o_dma_p2_reads_en)
				p2_pend <= 1'b1;
			else if (i_dma_p2_ob_we)
				p2_pend <= 1'b0;
			if (o_dma_p3_reads_en)
				p3_pend <= 1'b1;
			else if (i_dma_p3_ob_we)
				p3_pend <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (i_dma_p2_ob_we)
			o_elem_data <= i_dma_p2_ob_data;
		if (i_dma_p3_ob_we)
			o_elem_weight <= i_dma_p3_ob_data;
	end

	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			elem_cnt <= '0;
			out_cnt <= '0;
		end else if (o_start) begin
			elem_cnt <= '0;
			out_cnt <= '0;
		end else begin
			if (o_elem_en)
				elem_cnt <= o_elem_last ? '0 : elem_cnt + engine_pkg::cnt_t'(1);
			if (write_taken)
				out_cnt <= out_cnt + engine_pkg::cnt_t'(1);
		end
	end

	a_p2_single: assert property (@(posedge clk) disable iff (!i_rst_n)
		o_dma_p2_reads_en |-> !p2_pend)
		else $error("p2 request issued while one is outstanding");
	a_p3_single: assert property (@(posedge clk) disable iff (!i_rst_n)
		o_dma_p3_reads_en |-> !p3_pend)
		else $error("p3 request issued while one is outstanding");
	a_p2_stray: assert property (@(posedge clk) disable iff (!i_rst_n)
		i_dma_p2_ob_we |-> p2_pend)
		else $error("p2 ob_we without a request");
	a_p3_stray: assert property (@(posedge clk) disable iff (!i_rst_n)
		i_dma_p3_ob_we |-> p3_pend)
		else $error("p3 ob_we without a request");

endmodule

`default_nettype wire

//--- hw/engine_mac.sv
`timescale 1ns/1ns
`default_nettype none

module engine_mac (
	input  logic               clk,
	input  logic               i_rst_n,
	input  logic               i_en,
	input  logic               i_first,
	input  logic               i_last,
	input  engine_pkg::data_t  i_data,
	input  engine_pkg::data_t  i_weight,
	output engine_pkg::data_t  o_result,
	output logic               o_result_valid
);

	logic signed [2*engine_pkg::DATA_W-1:0]            prod;
	engine_pkg::acc_t                                  acc_q;
	engine_pkg::acc_t                                  acc_nxt;
	engine_pkg::acc_t                                  scaled;
	logic [engine_pkg::ACC_W-engine_pkg::DATA_W:0]     hi;
	engine_pkg::data_t                                 sat;

	assign prod = $signed(i_data) * $signed(i_weight);
	assign acc_nxt = (i_first ? engine_pkg::acc_t'(0) : acc_q) + engine_pkg::acc_t'(prod);

	// Q16.16 product sum back to Q8.8
	assign scaled = acc_nxt >>> engine_pkg::FRAC_W;
	assign hi = scaled[engine_pkg::ACC_W-1:engine_pkg::DATA_W-1];

	always_comb begin
		if (&hi || ~|hi)
			sat = scaled[engine_pkg::DATA_W-1:0];
		else if (scaled[engine_pkg::ACC_W-1])
			sat = {1'b1, {(engine_pkg::DATA_W-1){1'b0}}};
		else
			sat = {1'b0, {(engine_pkg::DATA_W-1){1'b1}}};
	end

	always_ff @(posedge clk) begin
		if (i_en)
			acc_q <= acc_nxt;
		if (i_en && i_last)
			o_result <= sat;
	end

	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n)
			o_result_valid <= 1'b0;
		else
			o_result_valid <= i_en && i_last;
	end

endmodule

`default_nettype wire

//--- hw/engine_pkg.sv
`default_nettype none

package engine_pkg;

	localparam int ADDR_W  = 30;
	localparam int DATA_W  = 16;
	localparam int ACC_W   = 40;
	localparam int CNT_W   = 16;
	localparam int FRAC_W  = 8;
	localparam int SHIFT_W = $clog2(CNT_W);

	typedef logic [ADDR_W-1:0]        addr_t;
	typedef logic [DATA_W-1:0]        data_t;
	typedef logic [CNT_W-1:0]         cnt_t;
	typedef logic [SHIFT_W-1:0]       shift_t;
	typedef logic signed [ACC_W-1:0]  acc_t;

	// Values not listed here are treated as unknown ops
	typedef enum logic [2:0] {
		OP_NONE    = 3'd0,
		OP_CONV    = 3'd1,
		OP_MAXPOOL = 3'd4,
		OP_AVEPOOL = 3'd5
	} op_t;

	typedef enum logic [2:0] {
		S_IDLE,
		S_FETCH,
		S_WAIT,
		S_REDUCE,
		S_WRITE,
		S_DONE,
		S_RELEASE
	} ctrl_state_t;

endpackage

`default_nettype wire

//--- hw/engine_pool.sv
`timescale 1ns/1ns
`default_nettype none

module engine_pool (
	input  logic               clk,
	input  logic               i_rst_n,
	input  logic               i_en,
	input  logic               i_first,
	input  logic               i_last,
	input  logic               i_avg,
	input  engine_pkg::cnt_t   i_op_num,
	input  engine_pkg::data_t  i_data,
	output engine_pkg::data_t  o_result,
	output logic               o_result_valid
);

	engine_pkg::data_t  max_q;
	engine_pkg::data_t  max_nxt;
	engine_pkg::acc_t   sum_q;
	engine_pkg::acc_t   sum_nxt;
	engine_pkg::acc_t   avg;
	engine_pkg::shift_t shift;

	// Highest set bit gives the exact log2 of a power of two
	function automatic engine_pkg::shift_t msb_index(input engine_pkg::cnt_t n);
		engine_pkg::shift_t idx;
		idx = '0;
		for (int i = 0; i < engine_pkg::CNT_W; i++) begin
			if (n[i])
				idx = engine_pkg::shift_t'(i);
		end
		return idx;
	endfunction

	assign shift = msb_index(i_op_num);

	assign max_nxt = (i_first || ($signed(i_data) > $signed(max_q))) ? i_data : max_q;
	assign sum_nxt = (i_first ? engine_pkg::acc_t'(0) : sum_q) +
		engine_pkg::acc_t'($signed(i_data));
	assign avg = sum_nxt >>> shift;

	always_ff @(posedge clk) begin
		if (i_en) begin
			max_q <= max_nxt;
			sum_q <= sum_nxt;
		end
		if (i_en && i_last)
			o_result <= i_avg ? avg[engine_pkg::DATA_W-1:0] : max_nxt;
	end

	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n)
			o_result_valid <= 1'b0;
		else
			o_result_valid <= i_en && i_last;
	end

endmodule

`default_nettype wire

//--- hw/engine_top.sv
`timescale 1ns/1ns
`default_nettype none

module engine_top (
	input  logic               clk,
	input  logic               i_rst_n,
	input  logic               i_engine_valid,
	input  logic [2:0]         i_op_type,
	input  engine_pkg::cnt_t   i_op_num,
	input  engine_pkg::cnt_t   i_out_count,
	input  engine_pkg::addr_t  i_data_start_addr,
	input  engine_pkg::addr_t  i_weight_start_addr,
	input  engine_pkg::addr_t  i_result_start_addr,
	output logic               o_engine_ready,
	output logic               o_dma_p2_reads_en,
	output engine_pkg::addr_t  o_p2_addr,
	input  logic               i_dma_p2_ob_we,
	input  engine_pkg::data_t  i_dma_p2_ob_data,
	output logic               o_dma_p3_reads_en,
	output engine_pkg::addr_t  o_p3_addr,
	input  logic               i_dma_p3_ob_we,
	input  engine_pkg::data_t  i_dma_p3_ob_data,
	output logic               o_dma_p0_writes_en,
	output logic               o_dma_p0_ib_valid,
	output engine_pkg::addr_t  o_p0_addr,
	output engine_pkg::data_t  o_dma_p0_ib_data,
	input  logic               i_dma_p0_ib_re
);

	logic              fetch;
	logic              start;
	logic              elem_en;
	logic              elem_first;
	logic              elem_last;
	engine_pkg::data_t elem_data;
	engine_pkg::data_t elem_weight;
	logic              mac_sel;
	engine_pkg::data_t mac_result;
	logic              mac_valid;
	engine_pkg::data_t pool_result;
	logic              pool_valid;
	logic              write_done;
	logic              wb_busy;

	engine_ctrl u_ctrl (
		.clk               (clk),
		.i_rst_n           (i_rst_n),
		.i_engine_valid    (i_engine_valid),
		.i_op_type         (engine_pkg::op_t'(i_op_type)),
		.i_op_num          (i_op_num),
		.i_out_count       (i_out_count),
		.i_dma_p2_ob_we    (i_dma_p2_ob_we),
		.i_dma_p2_ob_data  (i_dma_p2_ob_data),
		.i_dma_p3_ob_we    (i_dma_p3_ob_we),
		.i_dma_p3_ob_data  (i_dma_p3_ob_data),
		.i_wb_busy         (wb_busy),
		.o_engine_ready    (o_engine_ready),
		.o_dma_p2_reads_en (o_dma_p2_reads_en),
		.o_dma_p3_reads_en (o_dma_p3_reads_en),
		.o_fetch           (fetch),
		.o_start           (start),
		.o_elem_en         (elem_en),
		.o_elem_first      (elem_first),
		.o_elem_last       (elem_last),
		.o_elem_data       (elem_data),
		.o_elem_weight     (elem_weight),
		.o_mac_sel         (mac_sel)
	);

	engine_addr_gen u_addr_gen (
		.clk                 (clk),
		.i_rst_n             (i_rst_n),
		.i_start             (start),
		.i_fetch             (fetch),
		.i_write_done        (write_done),
		.i_op_num            (i_op_num),
		.i_data_start_addr   (i_data_start_addr),
		.i_weight_start_addr (i_weight_start_addr),
		.i_result_start_addr (i_result_start_addr),
		.o_p2_addr           (o_p2_addr),
		.o_p3_addr           (o_p3_addr),
		.o_p0_addr           (o_p0_addr)
	);

	engine_mac u_mac (
		.clk            (clk),
		.i_rst_n        (i_rst_n),
		.i_en           (elem_en && mac_sel),
		.i_first        (elem_first),
		.i_last         (elem_last),
		.i_data         (elem_data),
		.i_weight       (elem_weight),
		.o_result       (mac_result),
		.o_result_valid (mac_valid)
	);

	engine_pool u_pool (
		.clk            (clk),
		.i_rst_n        (i_rst_n),
		.i_en           (elem_en && !mac_sel),
		.i_first        (elem_first),
		.i_last         (elem_last),
		.i_avg          (i_op_type == engine_pkg::OP_AVEPOOL),
		.i_op_num       (i_op_num),
		.i_data         (elem_data),
		.o_result       (pool_result),
		.o_result_valid (pool_valid)
	);

	engine_wb u_wb (
		.clk                (clk),
		.i_rst_n            (i_rst_n),
		.i_mac_valid        (mac_valid),
		.i_mac_result       (mac_result),
		.i_pool_valid       (pool_valid),
		.i_pool_result      (pool_result),
		.i_dma_p0_ib_re     (i_dma_p0_ib_re),
		.o_dma_p0_writes_en (o_dma_p0_writes_en),
		.o_dma_p0_ib_valid  (o_dma_p0_ib_valid),
		.o_dma_p0_ib_data   (o_dma_p0_ib_data),
		.o_write_done       (write_done),
		.o_busy             (wb_busy)
	);

endmodule

`default_nettype wire

//--- hw/engine_wb.sv
`timescale 1ns/1ns
`default_nettype none

module engine_wb (
	input  logic               clk,
	input  logic               i_rst_n,
	input  logic               i_mac_valid,
	input  engine_pkg::data_t  i_mac_result,
	input  logic               i_pool_valid,
	input  engine_pkg::data_t  i_pool_result,
	input  logic               i_dma_p0_ib_re,
	output logic               o_dma_p0_writes_en,
	output logic               o_dma_p0_ib_valid,
	output engine_pkg::data_t  o_dma_p0_ib_data,
	output logic               o_write_done,
	output logic               o_busy
);

	logic              hold_q;
	engine_pkg::data_t data_q;

	assign o_dma_p0_writes_en = hold_q;
	assign o_dma_p0_ib_valid = hold_q;
	assign o_dma_p0_ib_data = data_q;
	assign o_write_done = hold_q && i_dma_p0_ib_re;
	// Clear in the accept cycle so the FSM moves on without a bubble
	assign o_busy = hold_q && !i_dma_p0_ib_re;

	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n)
			hold_q <= 1'b0;
		else if (i_mac_valid || i_pool_valid)
			hold_q <= 1'b1;
		else if (o_write_done)
			hold_q <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (i_mac_valid)
			data_q <= i_mac_result;
		else if (i_pool_valid)
			data_q <= i_pool_result;
	end

	a_hold_stable: assert property (@(posedge clk) disable iff (!i_rst_n)
		o_dma_p0_ib_valid && !i_dma_p0_ib_re |=>
		o_dma_p0_ib_valid && $stable(o_dma_p0_ib_data))
		else $error("p0 write dropped or changed before ib_re");
	a_one_source: assert property (@(posedge clk) disable iff (!i_rst_n)
		!(i_mac_valid && i_pool_valid))
		else $error("mac and pool results in the same cycle");

endmodule

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
# Build the engine testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --assert -j 0 \
	--top-module engine_tb \
	-f all.f \
	-Mdir obj_dir \
	-o engine_sim

./obj_dir/engine_sim > sim.log 2>&1
cat sim.log

if grep -q "^TEST PASS$" sim.log; then
	exit 0
else
	exit 1
fi

//--- tests/dma_mem_model.sv
`timescale 1ns/1ns
`default_nettype none

module dma_mem_model (
	input  logic               clk,
	input  logic               i_rst_n,
	input  logic               i_p2_reads_en,
	input  engine_pkg::addr_t  i_p2_addr,
	output logic               o_p2_ob_we,
	output engine_pkg::data_t  o_p2_ob_data,
	input  logic               i_p3_reads_en,
	input  engine_pkg::addr_t  i_p3_addr,
	output logic               o_p3_ob_we,
	output engine_pkg::data_t  o_p3_ob_data,
	input  logic               i_p0_writes_en,
	input  logic               i_p0_ib_valid,
	input  engine_pkg::addr_t  i_p0_addr,
	input  engine_pkg::data_t  i_p0_ib_data,
	output logic               o_p0_ib_re
);

	localparam int DEPTH = 1024;
	localparam int LOG_DEPTH = 64;

	engine_pkg::data_t mem [DEPTH];
	engine_pkg::addr_t log_addr [LOG_DEPTH];
	engine_pkg::data_t log_data [LOG_DEPTH];
	int                log_cnt;

	logic       p2_busy;
	logic       p3_busy;
	logic [1:0] p2_wait;
	logic [1:0] p3_wait;
	logic [9:0] p2_idx;
	logic [9:0] p3_idx;
	logic       wr_armed;
	logic [2:0] wr_wait;

	// Four regions of small Q8.8, large magnitude, all negative and full range words
	function automatic engine_pkg::data_t fill_word(input logic [9:0] a);
		logic [15:0] h;
		h = ({6'd0, a} * 16'd40503 + 16'h01d3) ^ {a, a[9:4]};
		case (a[9:8])
			2'd0: return {{7{h[8]}}, h[8:0]};
			2'd1: return a[7] ? {3'b100, h[12:0]} : {3'b011, h[12:0]};
			2'd2: return {1'b1, h[14:0]};
			default: return h;
		endcase
	endfunction

	initial begin
		for (int a = 0; a < DEPTH; a++)
			mem[10'(a)] = fill_word(10'(a));
	end

	// Each read is answered 1 to 4 cycles after it is taken
	always @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			p2_busy <= 1'b0;
			p2_wait <= '0;
			p2_idx <= '0;
			o_p2_ob_we <= 1'b0;
			o_p2_ob_data <= '0;
		end else begin
			o_p2_ob_we <= 1'b0;
			if (i_p2_reads_en) begin
				p2_busy <= 1'b1;
				p2_wait <= 2'($urandom_range(3, 0));
				p2_idx <= i_p2_addr[9:0];
			end else if (p2_busy) begin
				if (p2_wait == 2'd0) begin
					p2_busy <= 1'b0;
					o_p2_ob_we <= 1'b1;
					o_p2_ob_data <= mem[p2_idx];
				end else begin
					p2_wait <= p2_wait - 2'd1;
				end
			end
		end
	end

	always @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			p3_busy <= 1'b0;
			p3_wait <= '0;
			p3_idx <= '0;
			o_p3_ob_we <= 1'b0;
			o_p3_ob_data <= '0;
		end else begin
			o_p3_ob_we <= 1'b0;
			if (i_p3_reads_en) begin
				p3_busy <= 1'b1;
				p3_wait <= 2'($urandom_range(3, 0));
				p3_idx <= i_p3_addr[9:0];
			end else if (p3_busy) begin
				if (p3_wait == 2'd0) begin
					p3_busy <= 1'b0;
					o_p3_ob_we <= 1'b1;
					o_p3_ob_data <= mem[p3_idx];
				end else begin
					p3_wait <= p3_wait - 2'd1;
				end
			end
		end
	end

	// Writes are only logged and leave the preload untouched
	always @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_p0_ib_re <= 1'b0;
			wr_armed <= 1'b0;
			wr_wait <= '0;
			log_cnt <= 0;
		end else if (o_p0_ib_re) begin
			o_p0_ib_re <= 1'b0;
			wr_armed <= 1'b0;
			if (i_p0_writes_en && i_p0_ib_valid) begin
				log_addr[log_cnt[5:0]] <= i_p0_addr;
				log_data[log_cnt[5:0]] <= i_p0_ib_data;
				log_cnt <= log_cnt + 1;
			end
		end else if (i_p0_writes_en && i_p0_ib_valid) begin
			if (!wr_armed) begin
				wr_armed <= 1'b1;
				wr_wait <= 3'($urandom_range(5, 0));
			end else if (wr_wait == 3'd0) begin
				o_p0_ib_re <= 1'b1;
			end else begin
				wr_wait <= wr_wait - 3'd1;
			end
		end
	end

endmodule

`default_nettype wire

//--- tests/engine_tb.sv
`timescale 1ns/1ns
`default_nettype none

module engine_tb;

	localparam int N_OPS = 9;
	localparam int TIMEOUT_CYCLES = 5000;

	logic              clk;
	logic              rst_n;
	logic              engine_valid;
	logic [2:0]        op_type;
	engine_pkg::cnt_t  op_num;
	engine_pkg::cnt_t  out_count;
	engine_pkg::addr_t data_addr;
	engine_pkg::addr_t weight_addr;
	engine_pkg::addr_t result_addr;
	logic              engine_ready;
	logic              p2_en;
	engine_pkg::addr_t p2_addr;
	logic              p2_we;
	engine_pkg::data_t p2_data;
	logic              p3_en;
	engine_pkg::addr_t p3_addr;
	logic              p3_we;
	engine_pkg::data_t p3_data;
	logic              p0_writes_en;
	logic              p0_valid;
	engine_pkg::addr_t p0_addr;
	engine_pkg::data_t p0_data;
	logic              p0_re;

	// One op table entry per test
	string             t_name [N_OPS];
	logic [2:0]        t_op [N_OPS];
	engine_pkg::cnt_t  t_num [N_OPS];
	engine_pkg::cnt_t  t_outs [N_OPS];
	engine_pkg::addr_t t_data [N_OPS];
	engine_pkg::addr_t t_weight [N_OPS];
	engine_pkg::addr_t t_result [N_OPS];
	engine_pkg::cnt_t  t_writes [N_OPS];

	int   errors = 0;
	int   test_errors = 0;
	int   passed = 0;
	int   reads_seen = 0;
	logic timed_out = 1'b0;

	engine_top u_dut (
		.clk (clk), .i_rst_n (rst_n),
		.i_engine_valid (engine_valid), .i_op_type (op_type),
		.i_op_num (op_num), .i_out_count (out_count),
		.i_data_start_addr (data_addr), .i_weight_start_addr (weight_addr),
		.i_result_start_addr (result_addr), .o_engine_ready (engine_ready),
		.o_dma_p2_reads_en (p2_en), .o_p2_addr (p2_addr),
		.i_dma_p2_ob_we (p2_we), .i_dma_p2_ob_data (p2_data),
		.o_dma_p3_reads_en (p3_en), .o_p3_addr (p3_addr),
		.i_dma_p3_ob_we (p3_we), .i_dma_p3_ob_data (p3_data),
		.o_dma_p0_writes_en (p0_writes_en), .o_dma_p0_ib_valid (p0_valid),
		.o_p0_addr (p0_addr), .o_dma_p0_ib_data (p0_data), .i_dma_p0_ib_re (p0_re)
	);

	dma_mem_model u_mem (
		.clk (clk), .i_rst_n (rst_n),
		.i_p2_reads_en (p2_en), .i_p2_addr (p2_addr),
		.o_p2_ob_we (p2_we), .o_p2_ob_data (p2_data),
		.i_p3_reads_en (p3_en), .i_p3_addr (p3_addr),
		.o_p3_ob_we (p3_we), .o_p3_ob_data (p3_data),
		.i_p0_writes_en (p0_writes_en), .i_p0_ib_valid (p0_valid),
		.i_p0_addr (p0_addr), .i_p0_ib_data (p0_data), .o_p0_ib_re (p0_re)
	);

	always #4 clk = ~clk;

	always @(posedge clk)
		reads_seen <= reads_seen + (p2_en ? 1 : 0) + (p3_en ? 1 : 0);

	task automatic check_data(input string sig, input int idx,
		input engine_pkg::data_t got, input engine_pkg::data_t exp);
		if (got !== exp) begin
			$display("Error: %s[%0d] is 0x%h, expected 0x%h", sig, idx, got, exp);
			errors++;
			test_errors++;
		end
	endtask

	task automatic check_addr(input string sig, input int idx,
		input engine_pkg::addr_t got, input engine_pkg::addr_t exp);
		if (got !== exp) begin
			$display("Error: %s[%0d] is 0x%h, expected 0x%h", sig, idx, got, exp);
			errors++;
			test_errors++;
		end
	endtask

	task automatic check_count(input string sig,
		input engine_pkg::cnt_t got, input engine_pkg::cnt_t exp);
		if (got !== exp) begin
			$display("Error: %s is 0x%h, expected 0x%h", sig, got, exp);
			errors++;
			test_errors++;
		end
	endtask

	task automatic note_failure(input string what);
		$display("%s", what);
		errors++;
		test_errors++;
	endtask

	task automatic set_entry(input int i, input string name, input logic [2:0] op,
		input int num, input int outs, input int d, input int w, input int r, input int wr);
		t_name[i] = name;
		t_op[i] = op;
		t_num[i] = engine_pkg::cnt_t'(num);
		t_outs[i] = engine_pkg::cnt_t'(outs);
		t_data[i] = engine_pkg::addr_t'(d);
		t_weight[i] = engine_pkg::addr_t'(w);
		t_result[i] = engine_pkg::addr_t'(r);
		t_writes[i] = engine_pkg::cnt_t'(wr);
	endtask

	function automatic longint word_at(input logic [9:0] a);
		return longint'($signed(u_mem.mem[a]));
	endfunction

	// Index of the highest set bit
	function automatic int msb_pos(input engine_pkg::cnt_t n);
		int pos;
		pos = 0;
		while ((n >> (pos + 1)) != '0)
			pos++;
		return pos;
	endfunction

	function automatic engine_pkg::data_t expected_result(input int i, input int j);
		logic [9:0] base;
		longint     acc;
		longint     best;
		longint     w;
		base = 10'(t_data[i]) + 10'(j) * 10'(t_num[i]);
		acc = longint'(0);
		best = word_at(base);
		for (int k = 0; k < int'(t_num[i]); k++) begin
			w = word_at(base + 10'(k));
			if (t_op[i] == engine_pkg::OP_CONV)
				acc += w * word_at(10'(t_weight[i]) + 10'(k));
			else
				acc += w;
			if (w > best)
				best = w;
		end
		if (t_op[i] == engine_pkg::OP_MAXPOOL)
			return engine_pkg::data_t'(best);
		if (t_op[i] == engine_pkg::OP_AVEPOOL)
			return engine_pkg::data_t'(acc >>> msb_pos(t_num[i]));
		// Q16.16 sum back to Q8.8 with clamping
		acc = acc >>> 8;
		if (acc > longint'(32767))
			return 16'h7fff;
		if (acc < longint'(-32768))
			return 16'h8000;
		return engine_pkg::data_t'(acc);
	endfunction

	task automatic run_op(input int i);
		int   wr_base;
		int   rd_base;
		int   writes;
		int   reads_exp;
		int   cycles;
		logic seen;
		logic known;
		test_errors = 0;
		wr_base = u_mem.log_cnt;
		rd_base = reads_seen;
		seen = 1'b0;
		cycles = 0;
		known = (t_op[i] == engine_pkg::OP_CONV) || (t_op[i] == engine_pkg::OP_MAXPOOL) ||
			(t_op[i] == engine_pkg::OP_AVEPOOL);
		if (t_op[i] == engine_pkg::OP_CONV)
			reads_exp = 2 * int'(t_num[i]) * int'(t_outs[i]);
		else
			reads_exp = known ? int'(t_num[i]) * int'(t_outs[i]) : 0;
		@(posedge clk);
		engine_valid <= 1'b1;
		op_type <= t_op[i];
		op_num <= t_num[i];
		out_count <= t_outs[i];
		data_addr <= t_data[i];
		weight_addr <= t_weight[i];
		result_addr <= t_result[i];
		while (!seen && cycles < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycles++;
			seen = engine_ready;
		end
		if (!seen) begin
			$display("Timeout: %s got no ready pulse within %0d cycles", t_name[i],
				TIMEOUT_CYCLES);
			timed_out = 1'b1;
			errors++;
		end else begin
			if (p0_valid || p0_writes_en)
				note_failure($sformatf("%s: ready pulsed while a write was pending", t_name[i]));
			engine_valid <= 1'b0;
			@(posedge clk);
			if (engine_ready)
				note_failure($sformatf("%s: ready stayed high past one cycle", t_name[i]));
			writes = u_mem.log_cnt - wr_base;
			check_count("write_count", engine_pkg::cnt_t'(writes), t_writes[i]);
			check_count("dma_reads", engine_pkg::cnt_t'(reads_seen - rd_base),
				engine_pkg::cnt_t'(reads_exp));
			if (!known)
				check_count("ready_latency", engine_pkg::cnt_t'(cycles - 1),
					engine_pkg::cnt_t'(2));
			for (int j = 0; j < writes && j < int'(t_writes[i]); j++) begin
				check_addr("o_p0_addr", j, u_mem.log_addr[6'(wr_base + j)],
					t_result[i] + engine_pkg::addr_t'(j));
				check_data("o_dma_p0_ib_data", j, u_mem.log_data[6'(wr_base + j)],
					expected_result(i, j));
			end
			repeat (2) @(posedge clk);
			if (test_errors == 0) begin
				passed++;
				$display("%s: ok, %0d writes", t_name[i], writes);
			end else begin
				$display("%s: failed with %0d errors", t_name[i], test_errors);
			end
		end
	endtask

	initial begin
		void'($urandom(23));
		clk = 1'b0;
		rst_n = 1'b0;
		engine_valid = 1'b0;
		op_type = '0;
		op_num = '0;
		out_count = '0;
		data_addr = '0;
		weight_addr = '0;
		result_addr = '0;
		set_entry(0, "conv_3x3", 3'd1, 9, 3, 'h010, 'h060, 'h1000, 3);
		set_entry(1, "conv_sat_pos", 3'd1, 4, 2, 'h100, 'h140, 'h1100, 2);
		set_entry(2, "conv_sat_neg", 3'd1, 4, 2, 'h108, 'h180, 'h1200, 2);
		set_entry(3, "maxpool_neg", 3'd4, 4, 3, 'h200, 'h000, 'h1300, 3);
		set_entry(4, "maxpool_mixed", 3'd4, 9, 2, 'h300, 'h000, 'h1400, 2);
		set_entry(5, "avepool_4", 3'd5, 4, 3, 'h020, 'h000, 'h1500, 3);
		set_entry(6, "avepool_16", 3'd5, 16, 2, 'h040, 'h000, 'h1600, 2);
		set_entry(7, "avepool_6", 3'd5, 6, 2, 'h070, 'h000, 'h1700, 2);
		set_entry(8, "unknown_op", 3'd3, 4, 2, 'h000, 'h000, 'h1800, 0);
		repeat (4) @(posedge clk);
		rst_n <= 1'b1;
		repeat (2) @(posedge clk);
		if (engine_ready || p2_en || p3_en || p0_writes_en || p0_valid)
			note_failure("DMA or ready outputs are not idle after reset");
		for (int i = 0; i < N_OPS && !timed_out; i++)
			run_op(i);
		$display("%0d of %0d ops passed, %0d errors", passed, N_OPS, errors);
		if (errors == 0 && !timed_out)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

`default_nettype wire
